// File: Makefile
SIM      = verilator
TOP      = tb_clint
FILELIST = clint.f
OBJ_DIR  = obj_dir
FLAGS    = --binary --timing --assert -Wno-fatal -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR)

BIN     = $(OBJ_DIR)/V$(TOP)
SOURCES = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) -f $(FILELIST)

run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

// File: clint.f
source/clint_csr_pkg.sv
source/clint_trap_pkg.sv
source/trap_arbiter.sv
source/csr_write_sequencer.sv
source/clint_top.sv
verification/clint_asserts.sv
verification/tb_clint.sv

// File: source/clint_csr_pkg.sv
/* CSR map of the privileged architecture */

package clint_csr_pkg;

    // data and address widths
    localparam int XLEN       = 32;
    localparam int CSR_ADDR_W = 12;

    // machine and debug CSR addresses
    localparam logic [CSR_ADDR_W-1:0] CSR_MSTATUS = 12'h300;
    localparam logic [CSR_ADDR_W-1:0] CSR_MEPC    = 12'h341;
    localparam logic [CSR_ADDR_W-1:0] CSR_MCAUSE  = 12'h342;
    localparam logic [CSR_ADDR_W-1:0] CSR_DCSR    = 12'h7b0;
    localparam logic [CSR_ADDR_W-1:0] CSR_DPC     = 12'h7b1;

    // mstatus fields
    localparam int MSTATUS_MIE_BIT  = 3;
    localparam int MSTATUS_MPIE_BIT = 7;

    // dcsr cause field, bits 8:6
    localparam int DCSR_CAUSE_LSB = 6;
    localparam int DCSR_CAUSE_W   = 3;

    // mcause values
    localparam logic [XLEN-1:0] CAUSE_ECALL    = 32'd11; // ecall from M-mode
    localparam logic [XLEN-1:0] CAUSE_IRQ_BASE = 32'd8;  // irq id is added on top

    // debug entry cause written into dcsr
    localparam logic [DCSR_CAUSE_W-1:0] DCSR_CAUSE_DBGREQ = 3'd3;

endpackage

// File: source/clint_top.sv
/* Machine-mode trap controller */

`timescale 1ns/100ps

module clint_top (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                inst_valid_i,
    input  logic [clint_csr_pkg::XLEN-1:0]      inst_addr_i,
    input  logic                                ecall_i,
    input  logic                                mret_i,
    input  logic                                dret_i,
    input  logic                                int_req_i,
    input  logic [clint_trap_pkg::IRQ_ID_W-1:0] int_id_i,
    input  logic                                global_int_en_i,
    input  logic                                debug_req_i,
    input  logic [clint_csr_pkg::XLEN-1:0]      debug_halt_addr_i,
    input  clint_trap_pkg::csr_view_t           csr_i,
    input  logic                                csr_credit_i,
    output logic                                csr_wr_valid_o,
    output clint_trap_pkg::csr_wr_t             csr_wr_o,
    output logic                                redirect_valid_o,
    output logic [clint_csr_pkg::XLEN-1:0]      redirect_addr_o,
    output logic                                flush_o
);

    logic                      trap_valid;
    clint_trap_pkg::trap_req_t trap;
    logic                      busy;  // from acceptance through redirect

    trap_arbiter i_arbiter (
        .clk             (clk),
        .rst_n           (rst_n),
        .inst_valid_i    (inst_valid_i),
        .inst_addr_i     (inst_addr_i),
        .ecall_i         (ecall_i),
        .mret_i          (mret_i),
        .dret_i          (dret_i),
        .int_req_i       (int_req_i),
        .int_id_i        (int_id_i),
        .global_int_en_i (global_int_en_i),
        .debug_req_i     (debug_req_i),
        .seq_busy_i      (busy),
        .trap_valid_o    (trap_valid),
        .trap_o          (trap)
    );

    csr_write_sequencer i_sequencer (
        .clk               (clk),
        .rst_n             (rst_n),
        .trap_valid_i      (trap_valid),
        .trap_i            (trap),
        .csr_i             (csr_i),
        .debug_halt_addr_i (debug_halt_addr_i),
        .csr_credit_i      (csr_credit_i),
        .busy_o            (busy),
        .csr_wr_valid_o    (csr_wr_valid_o),
        .csr_wr_o          (csr_wr_o),
        .redirect_valid_o  (redirect_valid_o),
        .redirect_addr_o   (redirect_addr_o)
    );

    assign flush_o = busy; // pipeline held off while a trap runs

endmodule

// File: source/clint_trap_pkg.sv
/* Trap controller types */

package clint_trap_pkg;

    // interrupt id width
    localparam int IRQ_ID_W = 8;

    // credits held by the sequencer after reset
    localparam int CSR_WR_CREDITS = 2;
    localparam int CREDIT_W       = $clog2(CSR_WR_CREDITS + 1);

    typedef logic [CREDIT_W-1:0] credit_t;

    // kinds of trap the arbiter can hand over
    typedef enum logic [2:0] {
        TRAP_ECALL    = 3'd0,
        TRAP_IRQ      = 3'd1,
        TRAP_MRET     = 3'd2,
        TRAP_DBG_HALT = 3'd3,
        TRAP_DRET     = 3'd4
    } trap_kind_e;

    // CSR write sequencer states
    typedef enum logic [2:0] {
        S_IDLE           = 3'd0,
        S_WR_MEPC        = 3'd1,
        S_WR_MSTATUS     = 3'd2,
        S_WR_MCAUSE      = 3'd3,
        S_WR_MSTATUS_RET = 3'd4,
        S_WR_DPC         = 3'd5,
        S_WR_DCSR        = 3'd6,
        S_REDIRECT       = 3'd7
    } seq_state_e;

    typedef struct packed {
        trap_kind_e                     kind;
        logic [clint_csr_pkg::XLEN-1:0] cause; // mcause, or dcsr cause in low bits
        logic [clint_csr_pkg::XLEN-1:0] epc;   // pc of the trapping instruction
    } trap_req_t;

    typedef struct packed {
        logic [clint_csr_pkg::CSR_ADDR_W-1:0] addr;
        logic [clint_csr_pkg::XLEN-1:0]       data;
    } csr_wr_t;

    typedef struct packed {
        logic [clint_csr_pkg::XLEN-1:0] mtvec;
        logic [clint_csr_pkg::XLEN-1:0] mepc;
        logic [clint_csr_pkg::XLEN-1:0] mstatus;
        logic [clint_csr_pkg::XLEN-1:0] dpc;
        logic [clint_csr_pkg::XLEN-1:0] dcsr;
    } csr_view_t;

endpackage

// File: source/csr_write_sequencer.sv
/* CSR write sequencer */

`timescale 1ns/100ps

module csr_write_sequencer (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           trap_valid_i,
    input  clint_trap_pkg::trap_req_t      trap_i,
    input  clint_trap_pkg::csr_view_t      csr_i,
    input  logic [clint_csr_pkg::XLEN-1:0] debug_halt_addr_i,
    input  logic                           csr_credit_i,
    output logic                           busy_o,
    output logic                           csr_wr_valid_o,
    output clint_trap_pkg::csr_wr_t        csr_wr_o,
    output logic                           redirect_valid_o,
    output logic [clint_csr_pkg::XLEN-1:0] redirect_addr_o
);

    clint_trap_pkg::seq_state_e state_q;
    clint_trap_pkg::seq_state_e state_d;
    clint_trap_pkg::trap_req_t  trap_q;     // accepted trap
    clint_trap_pkg::credit_t    credits_q;  // free slots in the CSR file
    logic                       wr_state;
    logic                       has_credit;
    logic                       wr_fire;

    assign has_credit       = (credits_q != '0);
    assign wr_fire          = wr_state & has_credit;
    assign csr_wr_valid_o   = wr_fire;
    assign busy_o           = trap_valid_i | (state_q != clint_trap_pkg::S_IDLE);
    assign redirect_valid_o = (state_q == clint_trap_pkg::S_REDIRECT);

    // address and data of the write owned by each state
    always_comb begin
        wr_state      = 1'b1;
        csr_wr_o.addr = clint_csr_pkg::CSR_MSTATUS;
        csr_wr_o.data = csr_i.mstatus;
        case (state_q)
            clint_trap_pkg::S_WR_MEPC: begin
                csr_wr_o.addr = clint_csr_pkg::CSR_MEPC;
                csr_wr_o.data = trap_q.epc;
            end
            clint_trap_pkg::S_WR_MSTATUS: begin
                csr_wr_o.data[clint_csr_pkg::MSTATUS_MIE_BIT] = 1'b0; // mask on entry
            end
            clint_trap_pkg::S_WR_MCAUSE: begin
                csr_wr_o.addr = clint_csr_pkg::CSR_MCAUSE;
                csr_wr_o.data = trap_q.cause;
            end
            clint_trap_pkg::S_WR_MSTATUS_RET: begin
                csr_wr_o.data[clint_csr_pkg::MSTATUS_MIE_BIT] =
                    csr_i.mstatus[clint_csr_pkg::MSTATUS_MPIE_BIT];
            end
            clint_trap_pkg::S_WR_DPC: begin
                csr_wr_o.addr = clint_csr_pkg::CSR_DPC;
                csr_wr_o.data = trap_q.epc;
            end
            clint_trap_pkg::S_WR_DCSR: begin
                csr_wr_o.addr = clint_csr_pkg::CSR_DCSR;
                csr_wr_o.data = csr_i.dcsr;
                csr_wr_o.data[clint_csr_pkg::DCSR_CAUSE_LSB +: clint_csr_pkg::DCSR_CAUSE_W] =
                    trap_q.cause[clint_csr_pkg::DCSR_CAUSE_W-1:0];
            end
            default: begin
                wr_state = 1'b0; // idle and redirect issue nothing
            end
        endcase
    end

    // redirect target by trap kind
    always_comb begin
        case (trap_q.kind)
            clint_trap_pkg::TRAP_MRET:     redirect_addr_o = csr_i.mepc;
            clint_trap_pkg::TRAP_DBG_HALT: redirect_addr_o = debug_halt_addr_i;
            clint_trap_pkg::TRAP_DRET:     redirect_addr_o = csr_i.dpc;
            default:                       redirect_addr_o = csr_i.mtvec;
        endcase
    end

    // write states only move on when a credit is there
    always_comb begin
        state_d = state_q;
        case (state_q)
            clint_trap_pkg::S_IDLE: begin
                if (trap_valid_i) begin
                    case (trap_i.kind)
                        clint_trap_pkg::TRAP_ECALL,
                        clint_trap_pkg::TRAP_IRQ:      state_d = clint_trap_pkg::S_WR_MEPC;
                        clint_trap_pkg::TRAP_MRET:     state_d = clint_trap_pkg::S_WR_MSTATUS_RET;
                        clint_trap_pkg::TRAP_DBG_HALT: state_d = clint_trap_pkg::S_WR_DPC;
                        clint_trap_pkg::TRAP_DRET:     state_d = clint_trap_pkg::S_REDIRECT;
                        default:                       state_d = clint_trap_pkg::S_IDLE;
                    endcase
                end
            end
            clint_trap_pkg::S_WR_MEPC: begin
                if (has_credit) state_d = clint_trap_pkg::S_WR_MSTATUS;
            end
            clint_trap_pkg::S_WR_MSTATUS: begin
                if (has_credit) state_d = clint_trap_pkg::S_WR_MCAUSE;
            end
            clint_trap_pkg::S_WR_DPC: begin
                if (has_credit) state_d = clint_trap_pkg::S_WR_DCSR;
            end
            clint_trap_pkg::S_WR_MCAUSE,
            clint_trap_pkg::S_WR_MSTATUS_RET,
            clint_trap_pkg::S_WR_DCSR: begin
                if (has_credit) state_d = clint_trap_pkg::S_REDIRECT;
            end
            default: begin
                state_d = clint_trap_pkg::S_IDLE; // redirect lasts one cycle
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= clint_trap_pkg::S_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (trap_valid_i && state_q == clint_trap_pkg::S_IDLE) begin
            trap_q <= trap_i;
        end
    end

    // credit counter, saturates at the reset value
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credits_q <= clint_trap_pkg::credit_t'(clint_trap_pkg::CSR_WR_CREDITS);
        end else if (wr_fire && !csr_credit_i) begin
            credits_q <= credits_q - 1'b1;
        end else if (!wr_fire && csr_credit_i &&
                     credits_q != clint_trap_pkg::CSR_WR_CREDITS) begin
            credits_q <= credits_q + 1'b1;
        end
    end

endmodule

// File: source/trap_arbiter.sv
/* Trap request arbiter */

`timescale 1ns/100ps

module trap_arbiter (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic                                   inst_valid_i,
    input  logic [clint_csr_pkg::XLEN-1:0]         inst_addr_i,
    input  logic                                   ecall_i,
    input  logic                                   mret_i,
    input  logic                                   dret_i,
    input  logic                                   int_req_i,
    input  logic [clint_trap_pkg::IRQ_ID_W-1:0]    int_id_i,
    input  logic                                   global_int_en_i,
    input  logic                                   debug_req_i,
    input  logic                                   seq_busy_i,
    output logic                                   trap_valid_o,
    output clint_trap_pkg::trap_req_t              trap_o
);

    logic                                dbg_mode_q;  // halted in debug mode
    logic                                irq_ctx_q;   // interrupt handler open
    logic [clint_trap_pkg::IRQ_ID_W-1:0] last_id_q;   // id of last taken irq
    logic                                accept;
    logic                                irq_ok;
    logic                                pick_valid;
    clint_trap_pkg::trap_kind_e          pick_kind;
    logic [clint_csr_pkg::XLEN-1:0]      pick_cause;
    logic [clint_csr_pkg::XLEN-1:0]      irq_id_ext;

    // sequencer busy covers the trap_valid cycle as well
    assign accept = inst_valid_i & ~seq_busy_i;

    // repeat filter: a new id, or no handler running
    assign irq_ok = int_req_i & global_int_en_i &
                    ((int_id_i != last_id_q) | ~irq_ctx_q);

    assign irq_id_ext = {{(clint_csr_pkg::XLEN - clint_trap_pkg::IRQ_ID_W){1'b0}}, int_id_i};

    // fixed priority pick
    always_comb begin
        pick_valid = 1'b1;
        pick_kind  = clint_trap_pkg::TRAP_ECALL;
        pick_cause = '0;
        if (debug_req_i && !dbg_mode_q) begin
            pick_kind = clint_trap_pkg::TRAP_DBG_HALT;
            pick_cause[clint_csr_pkg::DCSR_CAUSE_W-1:0] = clint_csr_pkg::DCSR_CAUSE_DBGREQ;
        end else if (ecall_i && !dbg_mode_q) begin
            pick_kind  = clint_trap_pkg::TRAP_ECALL;
            pick_cause = clint_csr_pkg::CAUSE_ECALL;
        end else if (irq_ok && !dbg_mode_q) begin
            pick_kind  = clint_trap_pkg::TRAP_IRQ;
            pick_cause = clint_csr_pkg::CAUSE_IRQ_BASE + irq_id_ext;
        end else if (mret_i) begin
            pick_kind = clint_trap_pkg::TRAP_MRET; // cause unused on return
        end else if (dret_i && dbg_mode_q) begin
            pick_kind = clint_trap_pkg::TRAP_DRET;
        end else begin
            pick_valid = 1'b0;
        end
    end

    // one-cycle handshake pulse
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            trap_valid_o <= 1'b0;
        end else begin
            trap_valid_o <= accept & pick_valid;
        end
    end

    // trap payload, only sampled on a pick
    always_ff @(posedge clk) begin
        if (accept && pick_valid) begin
            trap_o.kind  <= pick_kind;
            trap_o.cause <= pick_cause;
            trap_o.epc   <= inst_addr_i;
        end
    end

    // mode and interrupt context tracking
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dbg_mode_q <= 1'b0;
            irq_ctx_q  <= 1'b0;
            last_id_q  <= '0;
        end else if (accept && pick_valid) begin
            case (pick_kind)
                clint_trap_pkg::TRAP_IRQ: begin
                    irq_ctx_q <= 1'b1;
                    last_id_q <= int_id_i;
                end
                clint_trap_pkg::TRAP_MRET: begin
                    irq_ctx_q <= 1'b0;
                end
                clint_trap_pkg::TRAP_DBG_HALT: begin
                    dbg_mode_q <= 1'b1;
                end
                clint_trap_pkg::TRAP_DRET: begin
                    dbg_mode_q <= 1'b0;
                end
                default: begin
                    dbg_mode_q <= dbg_mode_q; // ecall keeps both flags
                end
            endcase
        end
    end

endmodule

// File: verification/clint_asserts.sv
/* Sequencer protocol checks */

`timescale 1ns/100ps

module clint_asserts (
    input logic clk,
    input logic rst_n,
    input logic trap_valid_i,
    input logic csr_credit_i,
    input logic csr_wr_valid_o,
    input logic redirect_valid_o
);

    int   free_credits;  // credits as seen on the CSR port
    logic in_trap;       // between handshake and redirect

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            free_credits <= clint_trap_pkg::CSR_WR_CREDITS;
            in_trap      <= 1'b0;
        end else begin
            free_credits <= free_credits + int'(csr_credit_i) - int'(csr_wr_valid_o);
            if (trap_valid_i) in_trap <= 1'b1;
            else if (redirect_valid_o) in_trap <= 1'b0;
        end
    end

    // a write always spends a credit that exists
    assert property (@(posedge clk) disable iff (!rst_n)
        csr_wr_valid_o |-> (free_credits > 0))
        else $error("CSR write issued with no credit left");

    // redirect is a single-cycle pulse
    assert property (@(posedge clk) disable iff (!rst_n)
        redirect_valid_o |=> !redirect_valid_o)
        else $error("redirect held for more than one cycle");

    assert property (@(posedge clk) disable iff (!rst_n)
        csr_wr_valid_o |-> in_trap)
        else $error("CSR write issued while idle");

endmodule

bind csr_write_sequencer clint_asserts i_asserts (
    .clk              (clk),
    .rst_n            (rst_n),
    .trap_valid_i     (trap_valid_i),
    .csr_credit_i     (csr_credit_i),
    .csr_wr_valid_o   (csr_wr_valid_o),
    .redirect_valid_o (redirect_valid_o)
);

// File: verification/tb_clint.sv
/* Trap controller testbench */

`timescale 1ns/100ps

module tb_clint;

    logic clk, rst_n, inst_valid_i, ecall_i, mret_i, dret_i, int_req_i;
    logic global_int_en_i, debug_req_i, csr_credit_i;
    logic [31:0] inst_addr_i, debug_halt_addr_i;
    logic [7:0]  int_id_i;
    clint_trap_pkg::csr_view_t csr_i;
    clint_trap_pkg::csr_view_t view;       // CSR file contents
    logic csr_wr_valid_o, redirect_valid_o, flush_o;
    clint_trap_pkg::csr_wr_t csr_wr_o;
    logic [31:0] redirect_addr_o;

    logic [11:0] wr_addr_q[$];
    logic [31:0] wr_data_q[$];
    logic [31:0] redir_q[$];
    int          pend_q[$];                // cycle at which each credit returns
    int          cyc, credit_delay, outstanding, flush_cycles;
    int          issue_cyc, redir_cyc;     // cycles of the last request and redirect
    logic [31:0] lfsr;

    clint_top i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        string msg;
        if (got !== exp) begin
            msg = $sformatf("error at %0t: %s got %h expected %h", $time, name, got, exp);
            fail_run(msg);
        end
    endtask

    function automatic logic [31:0] next_lfsr(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // taps 32,22,2,1
    endfunction

    task automatic rand_word(output logic [31:0] w);
        w = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr = next_lfsr(lfsr);
            w = {w[30:0], lfsr[0]};
        end
        w[1:0] = 2'b00; // word aligned
    endtask

    // CSR file side: credit return and view update
    always @(posedge clk) begin
        cyc <= cyc + 1;
        csr_i <= view;
        if (pend_q.size() > 0 && pend_q[0] <= cyc + 1) begin
            csr_credit_i <= 1'b1;
            void'(pend_q.pop_front());
        end else begin
            csr_credit_i <= 1'b0;
        end
    end

    // sample DUT outputs away from the active edge
    always @(negedge clk) begin
        if (rst_n) begin
            if (inst_valid_i) issue_cyc = cyc;
            if (csr_credit_i) outstanding--;
            if (csr_wr_valid_o) begin
                wr_addr_q.push_back(csr_wr_o.addr);
                wr_data_q.push_back(csr_wr_o.data);
                pend_q.push_back(cyc + credit_delay);
                outstanding++;
                case (csr_wr_o.addr)
                    clint_csr_pkg::CSR_MSTATUS: view.mstatus = csr_wr_o.data;
                    clint_csr_pkg::CSR_MEPC:    view.mepc    = csr_wr_o.data;
                    clint_csr_pkg::CSR_DPC:     view.dpc     = csr_wr_o.data;
                    clint_csr_pkg::CSR_DCSR:    view.dcsr    = csr_wr_o.data;
                    default: ;                  // mcause is not viewed
                endcase
            end
            if (outstanding > 2) fail_run("more than two CSR writes outstanding");
            if (redirect_valid_o) begin
                redir_q.push_back(redirect_addr_o);
                redir_cyc = cyc;
                check("flush_o", {31'b0, flush_o}, 32'd1);
            end
            if (flush_o) flush_cycles++;
        end
    end

    task automatic clear_logs();
        wr_addr_q.delete();
        wr_data_q.delete();
        redir_q.delete();
        flush_cycles = 0;
    endtask

    task automatic issue(input logic [31:0] pc, input logic ec, input logic mr,
                         input logic dr, input logic irq, input logic [7:0] id,
                         input logic dbg);
        @(posedge clk);
        inst_valid_i <= 1'b1;
        inst_addr_i  <= pc;
        ecall_i      <= ec;
        mret_i       <= mr;
        dret_i       <= dr;
        int_req_i    <= irq;
        int_id_i     <= id;
        debug_req_i  <= dbg;
        @(posedge clk);
        inst_valid_i <= 1'b0;
        ecall_i      <= 1'b0;
        mret_i       <= 1'b0;
        dret_i       <= 1'b0;
        int_req_i    <= 1'b0;
        debug_req_i  <= 1'b0;
    endtask

    // wait for the redirect, then for all credits to come home
    task automatic finish_trap(input int n_wr, input logic [31:0] target);
        int t;
        t = 0;
        while (redir_q.size() == 0) begin
            @(posedge clk);
            t++;
            if (t > 200) fail_run("timeout waiting for redirect");
        end
        check("write count", wr_addr_q.size(), n_wr);
        check("redirect_addr_o", redir_q[0], target);
        check("flush cycles", flush_cycles, redir_cyc - issue_cyc); // flush up to redirect
        t = 0;
        while (pend_q.size() > 0 || csr_credit_i) begin
            @(posedge clk);
            t++;
            if (t > 200) fail_run("timeout waiting for credit return");
        end
        repeat (2) @(posedge clk);
    endtask

    task automatic check_wr(input int idx, input logic [11:0] addr, input logic [31:0] data);
        check("csr_wr_o.addr", {20'b0, wr_addr_q[idx]}, {20'b0, addr});
        check("csr_wr_o.data", wr_data_q[idx], data);
    endtask

    task automatic expect_silence();
        repeat (10) @(posedge clk);
        check("write count", wr_addr_q.size(), 0);
        check("redirect count", redir_q.size(), 0);
        check("flush cycles", flush_cycles, 0);
    endtask

    // shared by ecall and irq entry
    task automatic run_entry(input logic ec, input logic [7:0] id, input logic [31:0] cause);
        logic [31:0] pc, ms;
        rand_word(pc);
        ms = view.mstatus;
        ms[3] = 1'b0; // MIE masked on entry
        clear_logs();
        issue(pc, ec, 1'b0, 1'b0, !ec, id, 1'b0);
        finish_trap(3, view.mtvec);
        check_wr(0, clint_csr_pkg::CSR_MEPC, pc);
        check_wr(1, clint_csr_pkg::CSR_MSTATUS, ms);
        check_wr(2, clint_csr_pkg::CSR_MCAUSE, cause);
    endtask

    task automatic test_ecall();
        run_entry(1'b1, 8'd0, 32'd11);
    endtask

    task automatic test_irq();
        logic [31:0] ms;
        run_entry(1'b0, 8'd5, 32'd13);
        clear_logs();
        issue(32'h100, 1'b0, 1'b0, 1'b0, 1'b1, 8'd5, 1'b0); // repeat id filtered
        expect_silence();
        ms = view.mstatus;
        ms[3] = ms[7];
        issue(32'h104, 1'b0, 1'b1, 1'b0, 1'b0, 8'd0, 1'b0);
        finish_trap(1, view.mepc);
        check_wr(0, clint_csr_pkg::CSR_MSTATUS, ms);
        run_entry(1'b0, 8'd5, 32'd13);
    endtask

    task automatic test_irq_disabled();
        global_int_en_i <= 1'b0;
        clear_logs();
        issue(32'h200, 1'b0, 1'b0, 1'b0, 1'b1, 8'd7, 1'b0);
        expect_silence();
        global_int_en_i <= 1'b1;
    endtask

    task automatic test_backpressure();
        credit_delay = 6;
        run_entry(1'b1, 8'd0, 32'd11);
        credit_delay = 1;
    endtask

    task automatic test_debug();
        logic [31:0] pc, dcsr;
        rand_word(pc);
        dcsr = view.dcsr;
        dcsr[8:6] = 3'd3; // debugger request cause
        clear_logs();
        issue(pc, 1'b0, 1'b0, 1'b0, 1'b0, 8'd0, 1'b1);
        finish_trap(2, debug_halt_addr_i);
        check_wr(0, clint_csr_pkg::CSR_DPC, pc);
        check_wr(1, clint_csr_pkg::CSR_DCSR, dcsr);
        clear_logs();
        issue(32'h300, 1'b0, 1'b0, 1'b0, 1'b1, 8'd9, 1'b0); // masked in debug mode
        expect_silence();
        issue(32'h304, 1'b0, 1'b0, 1'b1, 1'b0, 8'd0, 1'b0);
        finish_trap(0, pc);
    endtask

    initial begin
        lfsr = 32'h4768_440f;
        rst_n = 1'b0;
        {inst_valid_i, ecall_i, mret_i, dret_i, int_req_i, debug_req_i, csr_credit_i} = '0;
        global_int_en_i = 1'b1;
        inst_addr_i = '0;
        int_id_i = '0;
        cyc = 0;
        credit_delay = 1;
        outstanding = 0;
        flush_cycles = 0;
        issue_cyc = 0;
        redir_cyc = 0;
        view = '0;
        rand_word(view.mtvec);
        rand_word(debug_halt_addr_i);
        view.mstatus = 32'h0000_0088; // MIE and MPIE set
        view.dcsr = 32'h4000_0003;
        csr_i = view;
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        repeat (2) @(posedge clk);
        test_ecall();
        test_irq();
        test_irq_disabled();
        test_backpressure();
        test_debug();
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule
